// File: source/dma_bus_pkg.sv
//////////////////////////////////////////////////
// Bus widths, table geometry and register map
// One descriptor per 32-byte stride, word select in addr [4:2]
// Memory port carries full words only, no byte enables
//////////////////////////////////////////////////

`default_nettype none

package dma_bus_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int addr_width_c = 32;
  localparam int data_width_c = 32;
  // Byte step between consecutive words
  localparam int word_bytes_c = data_width_c / 8;

  //////////////////////////////////////////////////
  // Request table and register map
  //////////////////////////////////////////////////

  localparam int table_entries_c   = 4;
  localparam int table_ptr_width_c = $clog2(table_entries_c);
  // Transfer length in words
  localparam int size_width_c      = 16;

  // Entry index above the stride, word offset below it
  localparam int entry_stride_c = 32;
  localparam int entry_lsb_c    = $clog2(entry_stride_c);
  localparam int word_lsb_c     = $clog2(word_bytes_c);
  localparam int word_width_c   = entry_lsb_c - word_lsb_c;

  // Word offsets inside one entry, offset 4 unused
  typedef enum logic [word_width_c-1:0] {
    REG_LADDR  = 0,
    REG_SIZE   = 1,
    REG_RADDR  = 2,
    REG_CTRL   = 3,
    REG_STATUS = 5
  } reg_word_e;

  // Memory master command, held until ack
  typedef struct packed {
    logic [addr_width_c-1:0] addr;
    logic                    we;
    logic [data_width_c-1:0] wdata;
  } mem_cmd_t;

endpackage

`default_nettype wire

// File: source/dma_req_pkg.sv
//////////////////////////////////////////////////
// Descriptor, table write and engine state types
// Both addresses live in the one memory behind the master port
//////////////////////////////////////////////////

`default_nettype none

package dma_req_pkg;

  import dma_bus_pkg::*;

  // Copy direction
  typedef enum logic {
    DIR_L2R = 1'b0,
    DIR_R2L = 1'b1
  } dma_dir_e;

  // One descriptor as stored in the table
  typedef struct packed {
    logic [addr_width_c-1:0] laddr;
    logic [addr_width_c-1:0] raddr;
    logic [size_width_c-1:0] size;
    dma_dir_e                dir;
  } dma_req_t;

  // Single field write from the slave port
  typedef struct packed {
    logic [table_ptr_width_c-1:0] pos;
    reg_word_e                    word;
    logic [data_width_c-1:0]      data;
  } tbl_wr_t;

  // Transfer engine FSM
  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_RD,
    ENG_RD_REL,
    ENG_WR,
    ENG_WR_REL,
    ENG_DONE
  } eng_state_e;

endpackage

`default_nettype wire

// File: source/dma_wb_interface.sv
//////////////////////////////////////////////////
// Wishbone slave decode, single-cycle ack
// No bursts, byte enables or error responses
// Only REG_STATUS reads back, all else reads zero
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_wb_interface
  import dma_bus_pkg::*;
  import dma_req_pkg::*;
(
  // Wishbone slave
  input  wire logic [addr_width_c-1:0]      wb_addr_i,
  input  wire logic [data_width_c-1:0]      wb_dat_i,
  input  wire logic                         wb_we_i,
  input  wire logic                         wb_cyc_i,
  input  wire logic                         wb_stb_i,
  output logic      [data_width_c-1:0]      wb_dat_o,
  output logic                              wb_ack_o,

  // Field writes into the table
  output logic                              tbl_wr_en_o,
  output tbl_wr_t                           tbl_wr_o,

  // Status access
  output logic      [table_ptr_width_c-1:0] stat_pos_o,
  output logic                              stat_set_en_o,
  output logic                              stat_rd_en_o,
  input  wire logic                         stat_done_i
);

  logic      acc;
  logic      is_stat;
  reg_word_e word;

  // Access completes in the cycle it is presented
  assign acc      = wb_cyc_i & wb_stb_i;
  assign wb_ack_o = acc;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign stat_pos_o = wb_addr_i[entry_lsb_c +: table_ptr_width_c];
  assign word       = reg_word_e'(wb_addr_i[word_lsb_c +: word_width_c]);
  assign is_stat    = (word == REG_STATUS);

  // Field word writes, the table drops unused offsets
  assign tbl_wr_en_o   = acc & wb_we_i & ~is_stat;
  assign tbl_wr_o.pos  = stat_pos_o;
  assign tbl_wr_o.word = word;
  assign tbl_wr_o.data = wb_dat_i;

  // Status write arms the entry, status read may free it
  assign stat_set_en_o = acc & wb_we_i & is_stat;
  assign stat_rd_en_o  = acc & ~wb_we_i & is_stat;

  // Read data, done flag in bit 0
  always_comb begin
    wb_dat_o = '0;
    if (is_stat && !wb_we_i) begin
      wb_dat_o = data_width_c'(stat_done_i);
    end
  end

endmodule

`default_nettype wire

// File: source/dma_request_table.sv
//////////////////////////////////////////////////
// Descriptor table with valid, done, in-flight flags
// Writes to a valid entry are dropped
// One job handed out at a time, lowest index first
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_request_table
  import dma_bus_pkg::*;
  import dma_req_pkg::*;
(
  input  wire logic                         clk,
  input  wire logic                         rst_i,

  // From the slave port
  input  wire logic                         tbl_wr_en_i,
  input  wire tbl_wr_t                      tbl_wr_i,
  input  wire logic [table_ptr_width_c-1:0] stat_pos_i,
  input  wire logic                         stat_set_en_i,
  input  wire logic                         stat_rd_en_i,
  output logic                              stat_done_o,

  // Job handshake to the engine
  output logic                              job_req_o,
  output dma_req_t                          job_o,
  input  wire logic                         job_ack_i,

  output logic                              done_o
);

  dma_req_t                     req_q [table_entries_c];
  logic [table_entries_c-1:0]   valid_q;
  logic [table_entries_c-1:0]   done_q;
  logic [table_entries_c-1:0]   inflight_q;
  logic [table_entries_c-1:0]   pending;
  logic [table_ptr_width_c-1:0] pick_idx;
  logic [table_ptr_width_c-1:0] cur_q;
  logic                         pick_vld;
  logic                         job_req_q;
  logic                         done_r;
  logic                         launch;
  logic                         fin;

  //////////////////////////////////////////////////
  // Selection of the next job
  //////////////////////////////////////////////////

  // Downward scan so the lowest index wins
  always_comb begin
    pending  = valid_q & ~done_q & ~inflight_q;
    pick_vld = 1'b0;
    pick_idx = '0;
    for (int i = table_entries_c - 1; i >= 0; i--) begin
      if (pending[i]) begin
        pick_vld = 1'b1;
        pick_idx = table_ptr_width_c'(i);
      end
    end
  end

  // New job only once the previous ack is gone
  assign launch = pick_vld & ~job_req_q & ~job_ack_i;
  assign fin    = job_req_q & job_ack_i;

  //////////////////////////////////////////////////
  // Flags and handshake
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q    <= '0;
      done_q     <= '0;
      inflight_q <= '0;
      job_req_q  <= 1'b0;
      cur_q      <= '0;
      done_r     <= 1'b0;
    end else begin
      done_r <= |done_q;
      // Arm a free entry
      if (stat_set_en_i && !valid_q[stat_pos_i]) begin
        valid_q[stat_pos_i] <= 1'b1;
        done_q[stat_pos_i]  <= 1'b0;
      end
      // Collected, entry becomes free
      if (stat_rd_en_i && done_q[stat_pos_i]) begin
        valid_q[stat_pos_i] <= 1'b0;
        done_q[stat_pos_i]  <= 1'b0;
      end
      if (launch) begin
        job_req_q            <= 1'b1;
        cur_q                <= pick_idx;
        inflight_q[pick_idx] <= 1'b1;
      end
      // Engine finished the whole copy
      if (fin) begin
        job_req_q         <= 1'b0;
        inflight_q[cur_q] <= 1'b0;
        done_q[cur_q]     <= 1'b1;
      end
    end
  end

  // Descriptor fields, free entries only
  always_ff @(posedge clk) begin
    if (tbl_wr_en_i && !valid_q[tbl_wr_i.pos]) begin
      case (tbl_wr_i.word)
        REG_LADDR: req_q[tbl_wr_i.pos].laddr <= tbl_wr_i.data;
        REG_SIZE:  req_q[tbl_wr_i.pos].size  <= tbl_wr_i.data[size_width_c-1:0];
        REG_RADDR: req_q[tbl_wr_i.pos].raddr <= tbl_wr_i.data;
        REG_CTRL:  req_q[tbl_wr_i.pos].dir   <= dma_dir_e'(tbl_wr_i.data[0]);
        default: ;
      endcase
    end
  end

  // Entry is valid while in flight, so job stays steady
  assign job_req_o   = job_req_q;
  assign job_o       = req_q[cur_q];
  assign stat_done_o = done_q[stat_pos_i];
  assign done_o      = done_r;

endmodule

`default_nettype wire

// File: source/dma_transfer_engine.sv
//////////////////////////////////////////////////
// Word copy engine on a four-phase memory port
// Two handshakes per word, read then write
// Job ack raised only when the whole copy is done
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_transfer_engine
  import dma_bus_pkg::*;
  import dma_req_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_i,

  // Job handshake from the table
  input  wire logic                    job_req_i,
  input  wire dma_req_t                job_i,
  output logic                         job_ack_o,

  // Memory master
  output logic                         mem_req_o,
  output mem_cmd_t                     mem_cmd_o,
  input  wire logic                    mem_ack_i,
  input  wire logic [data_width_c-1:0] mem_rdata_i
);

  eng_state_e              state_q;
  eng_state_e              state_d;
  logic [addr_width_c-1:0] src_q;
  logic [addr_width_c-1:0] dst_q;
  logic [size_width_c-1:0] cnt_q;
  logic [data_width_c-1:0] data_q;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE: begin
        // Zero-length job skips the memory entirely
        if (job_req_i) begin
          state_d = (job_i.size == '0) ? ENG_DONE : ENG_RD;
        end
      end
      ENG_RD: begin
        if (mem_ack_i) state_d = ENG_RD_REL;
      end
      ENG_RD_REL: begin
        if (!mem_ack_i) state_d = ENG_WR;
      end
      ENG_WR: begin
        if (mem_ack_i) state_d = ENG_WR_REL;
      end
      ENG_WR_REL: begin
        // Counter already stepped on the write ack
        if (!mem_ack_i) begin
          state_d = (cnt_q == '0) ? ENG_DONE : ENG_RD;
        end
      end
      ENG_DONE: begin
        if (!job_req_i) state_d = ENG_IDLE;
      end
      default: state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ENG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Address, count and data path
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (state_q)
      ENG_IDLE: begin
        // Source and destination follow dir
        if (job_req_i) begin
          src_q <= (job_i.dir == DIR_L2R) ? job_i.laddr : job_i.raddr;
          dst_q <= (job_i.dir == DIR_L2R) ? job_i.raddr : job_i.laddr;
          cnt_q <= job_i.size;
        end
      end
      ENG_RD: begin
        // Read data only valid during ack
        if (mem_ack_i) data_q <= mem_rdata_i;
      end
      ENG_WR: begin
        if (mem_ack_i) begin
          src_q <= src_q + addr_width_c'(word_bytes_c);
          dst_q <= dst_q + addr_width_c'(word_bytes_c);
          cnt_q <= cnt_q - 1'b1;
        end
      end
      default: ;
    endcase
  end

  // Command held stable from state and registers
  assign mem_req_o       = (state_q == ENG_RD) || (state_q == ENG_WR);
  assign mem_cmd_o.addr  = (state_q == ENG_WR) ? dst_q : src_q;
  assign mem_cmd_o.we    = (state_q == ENG_WR);
  assign mem_cmd_o.wdata = data_q;
  assign job_ack_o       = (state_q == ENG_DONE);

endmodule

`default_nettype wire

// File: source/dma_top.sv
//////////////////////////////////////////////////
// DMA tile top, slave port in and memory port out
// done_o is registered, one cycle behind the flags
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_top
  import dma_bus_pkg::*;
  import dma_req_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_i,

  // Wishbone slave
  input  wire logic [addr_width_c-1:0] wb_addr_i,
  input  wire logic [data_width_c-1:0] wb_dat_i,
  input  wire logic                    wb_we_i,
  input  wire logic                    wb_cyc_i,
  input  wire logic                    wb_stb_i,
  output logic      [data_width_c-1:0] wb_dat_o,
  output logic                         wb_ack_o,

  // Memory master
  output logic                         mem_req_o,
  output mem_cmd_t                     mem_cmd_o,
  input  wire logic                    mem_ack_i,
  input  wire logic [data_width_c-1:0] mem_rdata_i,

  // Any entry done and not collected
  output logic                         done_o
);

  // Slave port to table
  logic                         tbl_wr_en;
  tbl_wr_t                      tbl_wr;
  logic [table_ptr_width_c-1:0] stat_pos;
  logic                         stat_set_en;
  logic                         stat_rd_en;
  logic                         stat_done;

  // Table to engine
  logic                         job_req;
  logic                         job_ack;
  dma_req_t                     job;

  dma_wb_interface i_wb_interface (
    .wb_addr_i     (wb_addr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .tbl_wr_en_o   (tbl_wr_en),
    .tbl_wr_o      (tbl_wr),
    .stat_pos_o    (stat_pos),
    .stat_set_en_o (stat_set_en),
    .stat_rd_en_o  (stat_rd_en),
    .stat_done_i   (stat_done)
  );

  dma_request_table i_request_table (
    .clk           (clk),
    .rst_i         (rst_i),
    .tbl_wr_en_i   (tbl_wr_en),
    .tbl_wr_i      (tbl_wr),
    .stat_pos_i    (stat_pos),
    .stat_set_en_i (stat_set_en),
    .stat_rd_en_i  (stat_rd_en),
    .stat_done_o   (stat_done),
    .job_req_o     (job_req),
    .job_o         (job),
    .job_ack_i     (job_ack),
    .done_o        (done_o)
  );

  dma_transfer_engine i_transfer_engine (
    .clk         (clk),
    .rst_i       (rst_i),
    .job_req_i   (job_req),
    .job_i       (job),
    .job_ack_o   (job_ack),
    .mem_req_o   (mem_req_o),
    .mem_cmd_o   (mem_cmd_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

`default_nettype wire

// File: sim/dma_tb.sv
//////////////////////////////////////////////////
// DMA testbench with a 1024-word memory model
// Byte addresses must stay below 4 KiB
// Needs assertions enabled in the simulator
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dma_tb
  import dma_bus_pkg::*;
  import dma_req_pkg::*;
();

  localparam int          mem_words_c   = 1024;
  // 8 + 5 + (6 + 5 + 4 + 3) + 0 copied words
  localparam int          total_words_c = 31;
  localparam int          timeout_c     = total_words_c * 200 + 2000;
  localparam logic [31:0] seed_c        = 32'h727c_9f6e;

  logic                    clk = 1'b0;
  logic                    rst_i;
  logic [addr_width_c-1:0] wb_addr_i;
  logic [data_width_c-1:0] wb_dat_i;
  logic                    wb_we_i;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic [data_width_c-1:0] wb_dat_o;
  logic                    wb_ack_o;
  logic                    mem_req_o;
  mem_cmd_t                mem_cmd_o;
  logic                    mem_ack_i = 1'b0;
  logic [data_width_c-1:0] mem_rdata_i = '0;
  logic                    done_o;

  // Memory model state
  logic [31:0]             mem [mem_words_c];
  logic [31:0]             rd_log [$];
  int                      req_count = 0;
  int                      delay_left = 0;
  logic                    armed = 1'b0;
  int                      errors = 0;

  always #50 clk = ~clk;

  dma_top i_dma_top (
    .clk         (clk),
    .rst_i       (rst_i),
    .wb_addr_i   (wb_addr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_we_i     (wb_we_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .mem_req_o   (mem_req_o),
    .mem_cmd_o   (mem_cmd_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .done_o      (done_o)
  );

  // Initial memory content, address XOR fixed tag
  function automatic logic [31:0] init_word(input logic [31:0] a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] reg_addr(input int pos, input reg_word_e w);
    return 32'(pos * entry_stride_c) + (32'(w) << word_lsb_c);
  endfunction

  //////////////////////////////////////////////////
  // Memory slave, four-phase with 0..3 cycle ack delay
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_i) begin
      mem_ack_i <= 1'b0;
      armed = 1'b0;
      for (int i = 0; i < mem_words_c; i++) begin
        mem[i] <= init_word(32'(i) << 2);
      end
    end else if (mem_ack_i) begin
      // Release phase
      if (!mem_req_o) mem_ack_i <= 1'b0;
    end else if (mem_req_o) begin
      if (!armed) begin
        armed = 1'b1;
        delay_left = $urandom_range(3, 0);
      end
      if (delay_left == 0) begin
        armed = 1'b0;
        mem_ack_i <= 1'b1;
        req_count++;
        if (mem_cmd_o.we) begin
          mem[mem_cmd_o.addr[11:2]] <= mem_cmd_o.wdata;
        end else begin
          mem_rdata_i <= mem[mem_cmd_o.addr[11:2]];
          rd_log.push_back(mem_cmd_o.addr);
        end
      end else begin
        delay_left--;
      end
    end
  end

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  cmd_held_a: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_cmd_o))
    else begin
      errors++;
      $display("ERROR mem_cmd_held: request or command changed before ack");
    end

  req_rise_a: assert property (@(posedge clk) disable iff (rst_i)
    $rose(mem_req_o) |-> !mem_ack_i)
    else begin
      errors++;
      $display("ERROR mem_req_rise: new request while ack still high");
    end

  wb_ack_a: assert property (@(posedge clk) wb_ack_o == (wb_cyc_i && wb_stb_i))
    else begin
      errors++;
      $display("ERROR wb_ack: expected %b, actual %b", wb_cyc_i && wb_stb_i, wb_ack_o);
    end

  //////////////////////////////////////////////////
  // Host tasks and checks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One Wishbone cycle, held until ack
  task automatic wb_access(input logic we, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    wb_addr_i <= addr;
    wb_dat_i  <= wdata;
    wb_we_i   <= we;
    wb_cyc_i  <= 1'b1;
    wb_stb_i  <= 1'b1;
    @(negedge clk);
    while (!wb_ack_o) @(negedge clk);
    rdata = wb_dat_o;
    @(posedge clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic program_entry(input int pos, input logic [31:0] laddr,
                               input logic [31:0] raddr, input int size, input dma_dir_e dir);
    logic [31:0] rd;
    wb_access(1'b1, reg_addr(pos, REG_LADDR), laddr, rd);
    wb_access(1'b1, reg_addr(pos, REG_RADDR), raddr, rd);
    wb_access(1'b1, reg_addr(pos, REG_SIZE), 32'(size), rd);
    wb_access(1'b1, reg_addr(pos, REG_CTRL), 32'(dir), rd);
  endtask

  task automatic arm_entry(input int pos);
    logic [31:0] rd;
    wb_access(1'b1, reg_addr(pos, REG_STATUS), 32'h1, rd);
  endtask

  // Poll until done, the read that returns 1 frees the entry
  task automatic collect_entry(input int pos);
    logic [31:0] rd;
    rd = '0;
    while (rd != 32'h1) begin
      wb_access(1'b0, reg_addr(pos, REG_STATUS), '0, rd);
    end
  endtask

  task automatic check_copy(input string name, input logic [31:0] src,
                            input logic [31:0] dst, input int n);
    for (int i = 0; i < n; i++) begin
      check_word(name, init_word(src + 32'(4 * i)), mem[(dst[11:2]) + 10'(i)]);
    end
  endtask

  // Only the first two destination regions are written so far
  task automatic check_untouched();
    logic [31:0] a;
    for (int i = 0; i < mem_words_c; i++) begin
      a = 32'(i) << 2;
      if (!(a >= 32'h400 && a < 32'h420) && !(a >= 32'h800 && a < 32'h814)) begin
        check_word("untouched", init_word(a), mem[i]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    int          base;
    int          off;
    int          cnt;
    void'($urandom(seed_c));
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    rst_i     = 1'b1;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    // Local to remote copy, status polling along the way
    program_entry(0, 32'h100, 32'h400, 8, DIR_L2R);
    arm_entry(0);
    wb_access(1'b0, reg_addr(0, REG_STATUS), '0, rd);
    check_word("status_before_done", 32'h0, rd);
    do @(negedge clk); while (!done_o);
    wb_access(1'b0, reg_addr(0, REG_STATUS), '0, rd);
    check_word("status_after_done", 32'h1, rd);
    wb_access(1'b0, reg_addr(0, REG_STATUS), '0, rd);
    check_word("status_after_free", 32'h0, rd);
    @(negedge clk);
    check_word("done_o_after_free", 32'h0, 32'(done_o));
    wb_access(1'b0, reg_addr(0, REG_LADDR), '0, rd);
    check_word("non_status_read", 32'h0, rd);
    check_copy("l2r_copy", 32'h100, 32'h400, 8);

    // Remote to local into another region
    program_entry(0, 32'h800, 32'h200, 5, DIR_R2L);
    arm_entry(0);
    collect_entry(0);
    check_copy("r2l_copy", 32'h200, 32'h800, 5);
    check_untouched();

    // All four entries queued, fields first then status words
    for (int k = 0; k < table_entries_c; k++) begin
      program_entry(k, 32'ha00 + 32'(k * 64), 32'hc00 + 32'(k * 64), 6 - k, DIR_L2R);
    end
    base = rd_log.size();
    for (int k = 0; k < table_entries_c; k++) begin
      arm_entry(k);
    end
    for (int k = 0; k < table_entries_c; k++) begin
      collect_entry(k);
    end
    off = base;
    for (int k = 0; k < table_entries_c; k++) begin
      check_copy("queued_copy", 32'ha00 + 32'(k * 64), 32'hc00 + 32'(k * 64), 6 - k);
      // First read of each job in entry order
      check_word("queued_order", 32'ha00 + 32'(k * 64), rd_log[off]);
      off += 6 - k;
    end

    // Zero-length job, no memory traffic expected
    program_entry(1, 32'h300, 32'h380, 0, DIR_L2R);
    cnt = req_count;
    arm_entry(1);
    collect_entry(1);
    check_word("zero_length_reqs", 32'(cnt), 32'(req_count));

    $display("Checks complete, %0d errors", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (timeout_c) @(posedge clk);
    $display("Timeout after %0d cycles, the DMA never finished", timeout_c);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/dma_bus_pkg.sv
source/dma_req_pkg.sv
source/dma_wb_interface.sv
source/dma_request_table.sv
source/dma_transfer_engine.sv
source/dma_top.sv
sim/dma_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dma_tb -f vlog.f -o dma_sim
./obj_dir/dma_sim | tee sim.log
if grep -q "^sim passed$" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi
